/* include/muldiv_defs.svh */
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// data word
`define MULDIV_XLEN 32

// operand with the extension bit on top
`define MULDIV_OPW 33

`define MULDIV_RD_W 5 // rd index

// id tag that lets results come back out of order
`define MULDIV_ID_W 4

`endif

/* src/muldiv_pkg.sv */
`default_nettype none
`include "muldiv_defs.svh"

package muldiv_pkg;

	typedef logic [`MULDIV_XLEN-1:0] xlen_t;
	typedef logic [`MULDIV_OPW-1:0] opnd_t; // word plus sign/zero extension bit
	typedef logic [`MULDIV_RD_W-1:0] rd_idx_t;
	typedef logic [`MULDIV_ID_W-1:0] inst_id_t;

	// funct3 order where bit 2 picks the divider
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_DIV    = 3'd4,
		OP_DIVU   = 3'd5,
		OP_REM    = 3'd6,
		OP_REMU   = 3'd7
	} muldiv_op_t;

	// one accumulate step per partial product
	typedef enum logic [2:0] {
		MS_IDLE,
		MS_CLR,
		MS_ACC_LL,
		MS_ACC_HL,
		MS_ACC_LH,
		MS_ACC_HH,
		MS_DONE
	} mul_step_t;

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_RUN,
		DS_FIX,
		DS_DONE
	} div_state_t;

endpackage

`default_nettype wire

/* src/muldiv_ifs.sv */
`default_nettype none

// request toward one arithmetic unit
interface mul_req_if;
	muldiv_pkg::opnd_t op_a;
	muldiv_pkg::opnd_t op_b;
	logic sel; // mul high word / div remainder
	logic is_signed; // only the divider looks at this
	muldiv_pkg::rd_idx_t rd_id;
	muldiv_pkg::inst_id_t inst_id;
	logic valid;
	logic ready;

	modport src (
		output op_a, op_b, sel, is_signed, rd_id, inst_id, valid,
		input ready
	);
	modport dst (
		input op_a, op_b, sel, is_signed, rd_id, inst_id, valid,
		output ready
	);
endinterface

// tagged result from one unit
interface muldiv_res_if;
	muldiv_pkg::xlen_t data;
	muldiv_pkg::rd_idx_t rd_id;
	muldiv_pkg::inst_id_t inst_id;
	logic valid;
	logic ready;

	modport src (output data, rd_id, inst_id, valid, input ready);
	modport dst (input data, rd_id, inst_id, valid, output ready);
endinterface

`default_nettype wire

/* src/muldiv_issue.sv */
`default_nettype none

module muldiv_issue (
	input  muldiv_pkg::muldiv_op_t req_op,
	input  muldiv_pkg::xlen_t req_a,
	input  muldiv_pkg::xlen_t req_b,
	input  muldiv_pkg::rd_idx_t req_rd_id,
	input  muldiv_pkg::inst_id_t req_inst_id,
	input  logic req_valid,
	output logic req_ready,
	mul_req_if.src mul,
	mul_req_if.src div
);

	logic is_div;
	logic a_sgn; // multiplier operand a treated as signed
	logic b_sgn;
	logic div_sgn;

	// widen a word to the 33-bit operand
	function automatic muldiv_pkg::opnd_t ext(input muldiv_pkg::xlen_t v, input logic sgn);
		ext = {sgn & v[$left(v)], v};
	endfunction

	assign is_div = req_op[2];

	// MUL returns the low word, so the extension does not matter there
	assign a_sgn = (req_op == muldiv_pkg::OP_MUL) || (req_op == muldiv_pkg::OP_MULH)
		|| (req_op == muldiv_pkg::OP_MULHSU);
	assign b_sgn = (req_op == muldiv_pkg::OP_MUL) || (req_op == muldiv_pkg::OP_MULH);
	assign div_sgn = (req_op == muldiv_pkg::OP_DIV) || (req_op == muldiv_pkg::OP_REM);

	assign mul.op_a = ext(req_a, a_sgn);
	assign mul.op_b = ext(req_b, b_sgn);
	assign mul.sel = (req_op != muldiv_pkg::OP_MUL); // high word
	assign mul.is_signed = a_sgn & b_sgn;
	assign mul.rd_id = req_rd_id;
	assign mul.inst_id = req_inst_id;
	assign mul.valid = req_valid & ~is_div;

	assign div.op_a = ext(req_a, div_sgn);
	assign div.op_b = ext(req_b, div_sgn);
	assign div.sel = (req_op == muldiv_pkg::OP_REM) || (req_op == muldiv_pkg::OP_REMU);
	assign div.is_signed = div_sgn;
	assign div.rd_id = req_rd_id;
	assign div.inst_id = req_inst_id;
	assign div.valid = req_valid & is_div;

	// only the selected unit can stall the request
	assign req_ready = is_div ? div.ready : mul.ready;

endmodule

`default_nettype wire

/* src/muldiv_multiplier.sv */
`default_nettype none

module muldiv_multiplier (
	input  logic clk,
	input  logic resetn,
	mul_req_if.dst req,
	muldiv_res_if.src res
);

	// two-entry request buffer
	muldiv_pkg::opnd_t buf_a [2];
	muldiv_pkg::opnd_t buf_b [2];
	logic buf_sel [2];
	muldiv_pkg::rd_idx_t buf_rd [2];
	muldiv_pkg::inst_id_t buf_id [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] count;
	logic push;
	logic pop;

	muldiv_pkg::mul_step_t step;
	muldiv_pkg::opnd_t head_a;
	muldiv_pkg::opnd_t head_b;
	logic signed [17:0] mul_x;
	logic signed [17:0] mul_y;
	logic signed [35:0] part; // the one shared 18x18 product
	logic [47:0] acc_in;
	logic [47:0] acc; // product bits 64:17
	logic [16:0] low17;
	logic [64:0] product;

	logic out_load;
	logic out_valid;
	muldiv_pkg::xlen_t out_data;
	muldiv_pkg::rd_idx_t out_rd;
	muldiv_pkg::inst_id_t out_id;

	assign req.ready = (count != 2'd2);
	assign push = req.valid & req.ready;
	assign pop = out_load;

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			buf_a[wr_ptr] <= req.op_a;
			buf_b[wr_ptr] <= req.op_b;
			buf_sel[wr_ptr] <= req.sel;
			buf_rd[wr_ptr] <= req.rd_id;
			buf_id[wr_ptr] <= req.inst_id;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			if (push && !pop)
				count <= count + 2'd1;
			else if (!push && pop)
				count <= count - 2'd1;
		end
	end

	assign head_a = buf_a[rd_ptr];
	assign head_b = buf_b[rd_ptr];

	// low halves zero-extended, high halves sign-extended
	assign mul_x = ((step == muldiv_pkg::MS_ACC_HL) || (step == muldiv_pkg::MS_ACC_HH)) ?
		{{2{head_a[32]}}, head_a[32:17]} : {1'b0, head_a[16:0]};
	assign mul_y = ((step == muldiv_pkg::MS_ACC_LH) || (step == muldiv_pkg::MS_ACC_HH)) ?
		{{2{head_b[32]}}, head_b[32:17]} : {1'b0, head_b[16:0]};
	assign part = mul_x * mul_y;

	// align each partial product to bit 17 of the full product
	always_comb
	begin
		case (step)
			muldiv_pkg::MS_ACC_LL: acc_in = {29'd0, part[35:17]};
			muldiv_pkg::MS_ACC_HL,
			muldiv_pkg::MS_ACC_LH: acc_in = {{12{part[35]}}, part};
			muldiv_pkg::MS_ACC_HH: acc_in = {part[30:0], 17'd0};
			default: acc_in = 48'd0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (step == muldiv_pkg::MS_CLR)
			acc <= 48'd0;
		else
			acc <= acc + acc_in; // acc_in is zero outside the accumulate steps
		if (step == muldiv_pkg::MS_ACC_LL)
			low17 <= part[16:0];
	end

	assign product = {acc, low17};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			step <= muldiv_pkg::MS_IDLE;
		else
		begin
			case (step)
				muldiv_pkg::MS_IDLE: if (count != 2'd0) step <= muldiv_pkg::MS_CLR;
				muldiv_pkg::MS_CLR: step <= muldiv_pkg::MS_ACC_LL;
				muldiv_pkg::MS_ACC_LL: step <= muldiv_pkg::MS_ACC_HL;
				muldiv_pkg::MS_ACC_HL: step <= muldiv_pkg::MS_ACC_LH;
				muldiv_pkg::MS_ACC_LH: step <= muldiv_pkg::MS_ACC_HH;
				muldiv_pkg::MS_ACC_HH: step <= muldiv_pkg::MS_DONE;
				muldiv_pkg::MS_DONE: if (out_load) step <= muldiv_pkg::MS_IDLE;
				default: step <= muldiv_pkg::MS_IDLE;
			endcase
		end
	end

	// output register takes the product when empty or draining
	assign out_load = (step == muldiv_pkg::MS_DONE) & (~out_valid | res.ready);

	always_ff @(posedge clk)
	begin
		if (out_load)
		begin
			out_data <= buf_sel[rd_ptr] ? product[63:32] : product[31:0];
			out_rd <= buf_rd[rd_ptr];
			out_id <= buf_id[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			out_valid <= 1'b0;
		else if (out_load)
			out_valid <= 1'b1;
		else if (res.ready)
			out_valid <= 1'b0;
	end

	assign res.data = out_data;
	assign res.rd_id = out_rd;
	assign res.inst_id = out_id;
	assign res.valid = out_valid;

endmodule

`default_nettype wire

/* src/muldiv_divider.sv */
`default_nettype none
`include "muldiv_defs.svh"

module muldiv_divider (
	input  logic clk,
	input  logic resetn,
	mul_req_if.dst req,
	muldiv_res_if.src res
);

	muldiv_pkg::div_state_t state;
	logic [5:0] cnt; // shift step within RUN
	logic accept;
	logic a_neg;
	logic b_neg;
	muldiv_pkg::opnd_t mag_a;
	muldiv_pkg::opnd_t mag_b;

	muldiv_pkg::opnd_t dvs; // divisor magnitude
	muldiv_pkg::opnd_t quo; // dividend bits shift out, quotient bits shift in
	muldiv_pkg::opnd_t rem;
	logic [`MULDIV_OPW:0] trial;
	logic [`MULDIV_OPW:0] diff;
	logic q_neg;
	logic r_neg;
	logic dvz; // divide by zero
	logic sel;
	muldiv_pkg::xlen_t dividend;
	muldiv_pkg::xlen_t q_fix;
	muldiv_pkg::xlen_t r_fix;
	muldiv_pkg::xlen_t data;
	muldiv_pkg::rd_idx_t rd_id;
	muldiv_pkg::inst_id_t inst_id;

	assign req.ready = (state == muldiv_pkg::DS_IDLE);
	assign accept = req.valid & req.ready;

	assign a_neg = req.is_signed & req.op_a[`MULDIV_OPW-1];
	assign b_neg = req.is_signed & req.op_b[`MULDIV_OPW-1];
	assign mag_a = a_neg ? -req.op_a : req.op_a;
	assign mag_b = b_neg ? -req.op_b : req.op_b;

	// one restoring step
	assign trial = {rem, quo[`MULDIV_OPW-1]};
	assign diff = trial - {1'b0, dvs};

	// most negative / -1 already gives the dividend and zero here
	always_comb
	begin
		q_fix = q_neg ? -quo[`MULDIV_XLEN-1:0] : quo[`MULDIV_XLEN-1:0];
		r_fix = r_neg ? -rem[`MULDIV_XLEN-1:0] : rem[`MULDIV_XLEN-1:0];
		if (dvz)
		begin
			q_fix = '1;
			r_fix = dividend;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			quo <= mag_a;
			rem <= '0;
			dvs <= mag_b;
			q_neg <= a_neg ^ b_neg;
			r_neg <= a_neg; // remainder follows the dividend
			dvz <= (req.op_b == '0);
			sel <= req.sel;
			dividend <= req.op_a[`MULDIV_XLEN-1:0];
			rd_id <= req.rd_id;
			inst_id <= req.inst_id;
		end
		else if (state == muldiv_pkg::DS_RUN)
		begin
			rem <= diff[`MULDIV_OPW] ? trial[`MULDIV_OPW-1:0] : diff[`MULDIV_OPW-1:0];
			quo <= {quo[`MULDIV_OPW-2:0], ~diff[`MULDIV_OPW]};
		end
		if (state == muldiv_pkg::DS_FIX)
			data <= sel ? r_fix : q_fix;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= muldiv_pkg::DS_IDLE;
			cnt <= 6'd0;
		end
		else
		begin
			case (state)
				muldiv_pkg::DS_IDLE:
					if (accept)
					begin
						state <= muldiv_pkg::DS_RUN;
						cnt <= 6'd0;
					end
				muldiv_pkg::DS_RUN:
				begin
					cnt <= cnt + 6'd1;
					if (cnt == 6'(`MULDIV_OPW - 1))
						state <= muldiv_pkg::DS_FIX;
				end
				muldiv_pkg::DS_FIX: state <= muldiv_pkg::DS_DONE;
				muldiv_pkg::DS_DONE: if (res.ready) state <= muldiv_pkg::DS_IDLE;
				default: state <= muldiv_pkg::DS_IDLE;
			endcase
		end
	end

	assign res.valid = (state == muldiv_pkg::DS_DONE);
	assign res.data = data;
	assign res.rd_id = rd_id;
	assign res.inst_id = inst_id;

endmodule

`default_nettype wire

/* src/muldiv_result_arbiter.sv */
`default_nettype none

module muldiv_result_arbiter (
	input  logic clk,
	input  logic resetn,
	muldiv_res_if.dst mul,
	muldiv_res_if.dst div,
	output muldiv_pkg::xlen_t res_data,
	output muldiv_pkg::rd_idx_t res_rd_id,
	output muldiv_pkg::inst_id_t res_inst_id,
	output logic res_valid,
	input  logic res_ready
);

	logic grant_div;
	logic hold_mul; // a stalled multiplier result keeps the output

	// divider first, unless a multiplier result is already on show
	assign grant_div = div.valid & ~hold_mul;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			hold_mul <= 1'b0;
		else
			hold_mul <= mul.valid & ~grant_div & ~res_ready;
	end

	assign res_valid = div.valid | mul.valid;
	assign res_data = grant_div ? div.data : mul.data;
	assign res_rd_id = grant_div ? div.rd_id : mul.rd_id;
	assign res_inst_id = grant_div ? div.inst_id : mul.inst_id;

	// ready goes to the winner only
	assign div.ready = res_ready & grant_div;
	assign mul.ready = res_ready & ~grant_div;

endmodule

`default_nettype wire

/* src/muldiv_unit.sv */
`default_nettype none

module muldiv_unit (
	input  logic clk,
	input  logic resetn,

	input  muldiv_pkg::muldiv_op_t req_op,
	input  muldiv_pkg::xlen_t req_a,
	input  muldiv_pkg::xlen_t req_b,
	input  muldiv_pkg::rd_idx_t req_rd_id,
	input  muldiv_pkg::inst_id_t req_inst_id,
	input  logic req_valid,
	output logic req_ready,

	output muldiv_pkg::xlen_t res_data,
	output muldiv_pkg::rd_idx_t res_rd_id,
	output muldiv_pkg::inst_id_t res_inst_id,
	output logic res_valid,
	input  logic res_ready
);

	mul_req_if mul_req ();
	mul_req_if div_req ();
	muldiv_res_if mul_res ();
	muldiv_res_if div_res ();

	muldiv_issue i_issue (
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.req_rd_id(req_rd_id),
		.req_inst_id(req_inst_id),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.mul(mul_req.src),
		.div(div_req.src)
	);

	muldiv_multiplier i_mul (
		.clk(clk),
		.resetn(resetn),
		.req(mul_req.dst),
		.res(mul_res.src)
	);

	muldiv_divider i_div (
		.clk(clk),
		.resetn(resetn),
		.req(div_req.dst),
		.res(div_res.src)
	);

	muldiv_result_arbiter i_arb (
		.clk(clk),
		.resetn(resetn),
		.mul(mul_res.dst),
		.div(div_res.dst),
		.res_data(res_data),
		.res_rd_id(res_rd_id),
		.res_inst_id(res_inst_id),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

endmodule

`default_nettype wire

/* tests/muldiv_clk_gen.sv */
`default_nettype none

module muldiv_clk_gen (
	output logic clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// ten rising edges in reset, release on a falling edge
	initial
	begin
		resetn = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* tests/muldiv_properties.sv */
`default_nettype none

module muldiv_properties (
	input logic clk,
	input logic resetn,
	input muldiv_pkg::muldiv_op_t req_op,
	input muldiv_pkg::xlen_t req_a,
	input muldiv_pkg::xlen_t req_b,
	input muldiv_pkg::rd_idx_t req_rd_id,
	input muldiv_pkg::inst_id_t req_inst_id,
	input logic req_valid,
	input logic req_ready,
	input muldiv_pkg::xlen_t res_data,
	input muldiv_pkg::rd_idx_t res_rd_id,
	input muldiv_pkg::inst_id_t res_inst_id,
	input logic res_valid,
	input logic res_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// a stalled result holds its fields
	res_hold: assert property (@(posedge clk) disable iff (!resetn)
		res_valid && !res_ready |=> res_valid && $stable(res_data)
			&& $stable(res_rd_id) && $stable(res_inst_id))
	else $error("result fields changed while the consumer stalled");

	// stalled request keeps valid and payload
	req_hold: assert property (@(posedge clk) disable iff (!resetn)
		req_valid && !req_ready |=> req_valid && $stable(req_op)
			&& $stable(req_a) && $stable(req_b) && $stable(req_rd_id)
			&& $stable(req_inst_id))
	else $error("request dropped or changed while the DUT stalled it");

	reset_quiet: assert property (@(posedge clk) $rose(resetn) |=> !res_valid)
	else $error("res_valid high in the first cycle after reset release");

endmodule

`default_nettype wire

/* tests/muldiv_tb.sv */
`default_nettype none
`include "muldiv_defs.svh"

module muldiv_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_IDS = 1 << `MULDIV_ID_W;
	localparam int N_REQ = 300 + 150 + 200 + 150;
	localparam int CYCLE_LIMIT = N_REQ * 40 + 200;

	logic clk;
	logic resetn;
	muldiv_pkg::muldiv_op_t req_op;
	muldiv_pkg::xlen_t req_a;
	muldiv_pkg::xlen_t req_b;
	muldiv_pkg::rd_idx_t req_rd_id;
	muldiv_pkg::inst_id_t req_inst_id;
	logic req_valid;
	logic req_ready;
	muldiv_pkg::xlen_t res_data;
	muldiv_pkg::rd_idx_t res_rd_id;
	muldiv_pkg::inst_id_t res_inst_id;
	logic res_valid;
	logic res_ready;

	logic [31:0] rng;
	int cycles = 0;
	int errors; // in the running test
	int n_pass;
	int n_fail;
	int n_out; // ids in flight
	int n_div_out;
	muldiv_pkg::inst_id_t next_id;

	// scoreboard indexed by inst_id
	muldiv_pkg::xlen_t exp_data [N_IDS];
	muldiv_pkg::rd_idx_t exp_rd [N_IDS];
	logic busy [N_IDS];
	logic from_div [N_IDS];
	muldiv_pkg::inst_id_t mul_order [$]; // multiplies in issue order

	muldiv_clk_gen i_clk (
		.clk(clk),
		.resetn(resetn)
	);

	muldiv_unit i_dut (
		.clk(clk),
		.resetn(resetn),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.req_rd_id(req_rd_id),
		.req_inst_id(req_inst_id),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.res_data(res_data),
		.res_rd_id(res_rd_id),
		.res_inst_id(res_inst_id),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	bind muldiv_unit muldiv_properties i_props (
		.clk(clk),
		.resetn(resetn),
		.req_op(req_op),
		.req_a(req_a),
		.req_b(req_b),
		.req_rd_id(req_rd_id),
		.req_inst_id(req_inst_id),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.res_data(res_data),
		.res_rd_id(res_rd_id),
		.res_inst_id(res_inst_id),
		.res_valid(res_valid),
		.res_ready(res_ready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand32();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// corners one time in eight
	function logic [31:0] pick_operand();
		logic [31:0] r;
		logic [31:0] v;
		r = rand32();
		case (r[4:3])
			2'd0: v = 32'd0;
			2'd1: v = 32'hffff_ffff;
			2'd2: v = 32'h8000_0000;
			default: v = 32'd1;
		endcase
		if (r[2:0] != 3'd0)
			v = rand32();
		return v;
	endfunction

	// RISC-V M rules on 32-bit words
	function automatic muldiv_pkg::xlen_t expected_result(input muldiv_pkg::muldiv_op_t op,
			input logic [31:0] a, input logic [31:0] b);
		logic [63:0] a_s;
		logic [63:0] b_s;
		logic [63:0] a_u;
		logic [63:0] b_u;
		logic [63:0] p_ss;
		logic [63:0] p_su;
		logic [63:0] p_uu;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic ovf;
		muldiv_pkg::xlen_t r;
		a_s = {{32{a[31]}}, a};
		b_s = {{32{b[31]}}, b};
		a_u = {32'd0, a};
		b_u = {32'd0, b};
		p_ss = a_s * b_s; // low 64 bits of the signed product
		p_su = a_s * b_u;
		p_uu = a_u * b_u;
		sa = a;
		sb = b;
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			muldiv_pkg::OP_MUL: r = p_ss[31:0];
			muldiv_pkg::OP_MULH: r = p_ss[63:32];
			muldiv_pkg::OP_MULHSU: r = p_su[63:32];
			muldiv_pkg::OP_MULHU: r = p_uu[63:32];
			muldiv_pkg::OP_DIV:
				if (b == 32'd0)
					r = 32'hffff_ffff;
				else if (ovf)
					r = a;
				else
					r = sa / sb;
			muldiv_pkg::OP_DIVU: r = (b == 32'd0) ? 32'hffff_ffff : a / b;
			muldiv_pkg::OP_REM:
				if (b == 32'd0)
					r = a;
				else if (ovf)
					r = 32'd0;
				else
					r = sa % sb;
			default: r = (b == 32'd0) ? a : a % b;
		endcase
		return r;
	endfunction

	// kind 0 multiply, 1 divide, 2 mixed, 3 mostly multiply
	task automatic choose_request(input int kind, input int k);
		logic [31:0] r;
		r = rand32();
		case (kind)
			0: req_op = muldiv_pkg::muldiv_op_t'({1'b0, r[1:0]});
			1: req_op = muldiv_pkg::muldiv_op_t'({1'b1, r[1:0]});
			2: req_op = muldiv_pkg::muldiv_op_t'(r[2:0]);
			default: req_op = muldiv_pkg::muldiv_op_t'({(r[4:3] == 2'd0), r[1:0]});
		endcase
		req_a = pick_operand();
		req_b = pick_operand();
		req_rd_id = r[12:8];
		if (kind == 1 && k < 8)
		begin
			// overflow by -1 first, then zero divisors
			req_op = muldiv_pkg::muldiv_op_t'({1'b1, k[1:0]});
			req_a = 32'h8000_0000;
			req_b = (k < 4) ? 32'hffff_ffff : 32'd0;
		end
	endtask

	task automatic check_idle();
		assert (!res_valid) else
		begin
			$display("ERROR reset: res_valid expected 0 actual %0b", res_valid);
			errors++;
		end
		assert (req_ready) else
		begin
			$display("ERROR reset: req_ready expected 1 actual %0b", req_ready);
			errors++;
		end
	endtask

	task automatic check_result(input string name);
		muldiv_pkg::inst_id_t id;
		id = res_inst_id;
		assert (busy[id]) else
		begin
			$display("%s: result with id %0d arrived but no request used that id", name, id);
			errors++;
		end
		if (busy[id])
		begin
			assert (res_data == exp_data[id]) else
			begin
				$display("ERROR %s: id %0d data expected %h actual %h",
					name, id, exp_data[id], res_data);
				errors++;
			end
			assert (res_rd_id == exp_rd[id]) else
			begin
				$display("ERROR %s: id %0d rd_id expected %0d actual %0d",
					name, id, exp_rd[id], res_rd_id);
				errors++;
			end
			if (from_div[id])
				n_div_out--;
			else
			begin
				assert (mul_order.size() > 0 && mul_order[0] == id) else
				begin
					$display("%s: multiply id %0d returned ahead of an older multiply", name, id);
					errors++;
				end
				if (mul_order.size() > 0)
					void'(mul_order.pop_front());
			end
			busy[id] = 1'b0;
			n_out--;
		end
	endtask

	task automatic record_request(input string name, input logic div_busy);
		logic is_div;
		is_div = req_op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
			muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};
		exp_data[req_inst_id] = expected_result(req_op, req_a, req_b);
		exp_rd[req_inst_id] = req_rd_id;
		busy[req_inst_id] = 1'b1;
		from_div[req_inst_id] = is_div;
		n_out++;
		if (is_div)
		begin
			assert (!div_busy) else
			begin
				$display("%s: a divide was accepted while an earlier divide was in flight", name);
				errors++;
			end
			n_div_out++;
		end
		else
			mul_order.push_back(req_inst_id);
		next_id = next_id + muldiv_pkg::inst_id_t'(1);
	endtask

	task automatic finish_test(input string name);
		if (errors == 0)
		begin
			n_pass++;
			$display("test %s: pass", name);
		end
		else
		begin
			n_fail++;
			$display("test %s: FAIL with %0d errors", name, errors);
		end
		errors = 0;
	endtask

	task automatic run_test(input string name, input int kind, input int n_req,
			input int ready_pct);
		int issued;
		logic req_fire;
		logic res_fire;
		logic div_busy;
		issued = 0;
		req_fire = 1'b0;
		while (issued < n_req || n_out > 0)
		begin
			@(negedge clk);
			if (req_fire)
				req_valid = 1'b0;
			// next id must be free before it goes out again
			if (!req_valid && issued < n_req && !busy[next_id])
			begin
				choose_request(kind, issued);
				req_inst_id = next_id;
				req_valid = 1'b1;
			end
			res_ready = (rand32() % 100) < ready_pct;
			#1; // settled until the rising edge
			req_fire = req_valid & req_ready;
			res_fire = res_valid & res_ready;
			div_busy = (n_div_out > 0);
			if (res_fire)
				check_result(name);
			if (req_fire)
			begin
				record_request(name, div_busy);
				issued++;
			end
			@(posedge clk);
		end
		finish_test(name);
	endtask

	initial
	begin
		req_op = muldiv_pkg::OP_MUL;
		req_a = '0;
		req_b = '0;
		req_rd_id = '0;
		req_inst_id = '0;
		req_valid = 1'b0;
		res_ready = 1'b0;
		rng = 32'd68947;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		n_out = 0;
		n_div_out = 0;
		next_id = '0;
		for (int i = 0; i < N_IDS; i++)
			busy[i] = 1'b0;

		// through reset and one cycle past release
		@(negedge clk);
		#1;
		while (!resetn)
		begin
			check_idle();
			@(negedge clk);
			#1;
		end
		@(negedge clk); // first rising edge out of reset is behind us
		#1;
		check_idle();
		finish_test("reset");

		run_test("multiply", 0, 300, 75);
		run_test("divide", 1, 150, 75);
		run_test("mixed", 2, 200, 50);
		run_test("order", 3, 150, 25);

		$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
src/muldiv_pkg.sv
src/muldiv_ifs.sv
src/muldiv_issue.sv
src/muldiv_multiplier.sv
src/muldiv_divider.sv
src/muldiv_result_arbiter.sv
src/muldiv_unit.sv
tests/muldiv_clk_gen.sv
tests/muldiv_properties.sv
tests/muldiv_tb.sv

/* Makefile */
SRCS := $(wildcard src/*.sv tests/*.sv include/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vmuldiv_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module muldiv_tb -f project.f

run: obj_dir/Vmuldiv_tb
	obj_dir/Vmuldiv_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
